// File: logic/bcd_pkg.sv
`default_nettype none

package bcd_pkg;

  localparam int BIN_W   = 7;
  localparam int ITER_W  = 3;
  localparam int DIGIT_W = 4;
  localparam int SR_W    = 2 * DIGIT_W + BIN_W;  // Tens, units and the unconsumed binary bits.

  typedef logic [BIN_W-1:0]   bin_t;
  typedef logic [DIGIT_W-1:0] digit_t;
  typedef logic [ITER_W-1:0]  iter_t;

  localparam iter_t  LAST_ITER = iter_t'(BIN_W - 2);  // Six corrected shifts, then one plain shift.
  localparam digit_t GE_FIVE   = digit_t'(5);
  localparam digit_t ADJ_ADD   = digit_t'(3);

  // Sign bits of the two differences, tens in the upper bit.
  // A zero bit means that digit needs the add-3 correction.
  localparam logic [1:0] NEG_NONE = 2'b11;
  localparam logic [1:0] NEG_UND  = 2'b10;
  localparam logic [1:0] NEG_DEC  = 2'b01;
  localparam logic [1:0] NEG_ALL  = 2'b00;

  typedef enum logic [3:0] {
    st_start      = 4'b0000,
    st_shift      = 4'b0001,
    st_check_neg  = 4'b0010,
    st_load_und   = 4'b0011,
    st_load_dec   = 4'b0100,
    st_load_all   = 4'b0101,
    st_iterate    = 4'b0110,
    st_last_shift = 4'b0111,
    st_done       = 4'b1000
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/bcd_shift_control.sv
`timescale 1ns/10ps
`default_nettype none

module bcd_shift_control
  import bcd_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  logic   last_iter,
  input  digit_t und_diff,
  input  digit_t dec_diff,
  output logic   clear,
  output logic   shift_en,
  output logic   adj_en,
  output logic   adj_und,
  output logic   adj_dec,
  output logic   iter_en,
  output logic   done
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic [1:0]  neg_flags;

  assign neg_flags = {dec_diff[DIGIT_W-1], und_diff[DIGIT_W-1]};  // Only the signs matter here.

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_start;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_start: begin
        if (start) begin
          state_next = st_shift;
        end
      end
      st_shift: begin
        state_next = st_check_neg;
      end
      st_check_neg: begin
        case (neg_flags)
          NEG_NONE: state_next = st_iterate;
          NEG_UND:  state_next = st_load_und;
          NEG_DEC:  state_next = st_load_dec;
          NEG_ALL:  state_next = st_load_all;
          default:  state_next = st_iterate;
        endcase
      end
      st_load_und, st_load_dec, st_load_all: begin
        state_next = st_iterate;
      end
      st_iterate: begin
        state_next = last_iter ? st_last_shift : st_shift;  // The seventh shift skips the check.
      end
      st_last_shift: begin
        state_next = st_done;
      end
      st_done: begin
        state_next = st_start;
      end
      default: begin
        state_next = st_start;
      end
    endcase
  end

  // Strobes depend on the state alone.
  always_comb begin
    clear    = 1'b0;
    shift_en = 1'b0;
    adj_en   = 1'b0;
    adj_und  = 1'b0;
    adj_dec  = 1'b0;
    iter_en  = 1'b0;
    done     = 1'b0;
    case (state)
      st_start: begin
        clear = 1'b1;  // Keeps reloading the operand while idle.
      end
      st_shift, st_last_shift: begin
        shift_en = 1'b1;
      end
      st_load_und: begin
        adj_en  = 1'b1;
        adj_und = 1'b1;
      end
      st_load_dec: begin
        adj_en  = 1'b1;
        adj_dec = 1'b1;
      end
      st_load_all: begin
        adj_en  = 1'b1;
        adj_und = 1'b1;
        adj_dec = 1'b1;
      end
      st_iterate: begin
        iter_en = 1'b1;
      end
      st_done: begin
        done = 1'b1;
      end
      default: begin
        clear = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/bcd_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module bcd_datapath
  import bcd_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  bin_t   bin_in,
  input  logic   clear,
  input  logic   shift_en,
  input  logic   adj_en,
  input  logic   adj_und,
  input  logic   adj_dec,
  input  logic   iter_en,
  input  logic   done,
  output digit_t und_diff,
  output digit_t dec_diff,
  output logic   last_iter,
  output digit_t units,
  output digit_t tens
);

  logic [SR_W-1:0] shift_reg;
  logic [SR_W-1:0] shift_next;
  digit_t          und_cur;
  digit_t          dec_cur;
  digit_t          und_fix;
  digit_t          dec_fix;
  bin_t            bin_rest;
  iter_t           iter_cnt;

  // Layout is tens, units, then the binary bits still to be shifted in.
  assign dec_cur  = shift_reg[SR_W-1 -: DIGIT_W];
  assign und_cur  = shift_reg[BIN_W +: DIGIT_W];
  assign bin_rest = shift_reg[BIN_W-1:0];

  // A digit of five or more leaves the difference with a clear sign bit.
  assign und_diff = und_cur - GE_FIVE;
  assign dec_diff = dec_cur - GE_FIVE;

  always_comb begin
    und_fix = und_cur;
    dec_fix = dec_cur;
    if (adj_und) begin
      und_fix = und_cur + ADJ_ADD;
    end
    if (adj_dec) begin
      dec_fix = dec_cur + ADJ_ADD;
    end
  end

  always_comb begin
    shift_next = shift_reg;
    if (clear) begin
      shift_next = {{(2 * DIGIT_W){1'b0}}, bin_in};
    end else if (shift_en) begin
      shift_next = {shift_reg[SR_W-2:0], 1'b0};
    end else if (adj_en) begin
      shift_next = {dec_fix, und_fix, bin_rest};
    end
  end

  always_ff @(posedge clk) begin
    shift_reg <= shift_next;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      iter_cnt <= '0;
    end else if (iter_en) begin
      iter_cnt <= iter_cnt + iter_t'(1);
    end
  end

  assign last_iter = (iter_cnt == LAST_ITER);

  // Holds the digits of the last finished conversion.
  always_ff @(posedge clk) begin
    if (rst) begin
      units <= '0;
      tens  <= '0;
    end else if (done) begin
      units <= und_cur;
      tens  <= dec_cur;
    end
  end

endmodule

`default_nettype wire

// File: logic/bin_to_bcd.sv
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd
  import bcd_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  bin_t   bin_in,
  output digit_t units,
  output digit_t tens,
  output logic   done
);

  logic   clear;
  logic   shift_en;
  logic   adj_en;
  logic   adj_und;
  logic   adj_dec;
  logic   iter_en;
  logic   last_iter;
  digit_t und_diff;
  digit_t dec_diff;

  bcd_shift_control i_bcd_shift_control (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .last_iter (last_iter),
    .und_diff  (und_diff),
    .dec_diff  (dec_diff),
    .clear     (clear),
    .shift_en  (shift_en),
    .adj_en    (adj_en),
    .adj_und   (adj_und),
    .adj_dec   (adj_dec),
    .iter_en   (iter_en),
    .done      (done)
  );

  // The done strobe also loads the result register, so the outputs change one edge later.
  bcd_datapath i_bcd_datapath (
    .clk       (clk),
    .rst       (rst),
    .bin_in    (bin_in),
    .clear     (clear),
    .shift_en  (shift_en),
    .adj_en    (adj_en),
    .adj_und   (adj_und),
    .adj_dec   (adj_dec),
    .iter_en   (iter_en),
    .done      (done),
    .und_diff  (und_diff),
    .dec_diff  (dec_diff),
    .last_iter (last_iter),
    .units     (units),
    .tens      (tens)
  );

endmodule

`default_nettype wire

// File: bench/bin_to_bcd_assert.sv
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd_assert
  import bcd_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input ctrl_state_t state,
  input logic        clear,
  input logic        shift_en,
  input logic        adj_en,
  input logic        done
);

  int fail_count = 0;

  // The machine returns to start right after done.
  done_single_pulse: assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  ) else begin
    $error("done stayed high for more than one cycle");
    fail_count++;
  end

  // A correction and a shift must never share a cycle.
  adj_not_with_shift: assert property (
    @(posedge clk) disable iff (rst) !(adj_en && shift_en)
  ) else begin
    $error("adj_en and shift_en high together");
    fail_count++;
  end

  clear_only_idle: assert property (
    @(posedge clk) disable iff (rst) clear |-> (state == st_start)
  ) else begin
    $error("clear high outside the start state");
    fail_count++;
  end

  // The last shift comes straight before done.
  done_after_shift: assert property (
    @(posedge clk) disable iff (rst) done |-> $past(shift_en)
  ) else begin
    $error("done without a shift in the cycle before");
    fail_count++;
  end

endmodule

`default_nettype wire

// File: bench/bin_to_bcd_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd_tb
  import bcd_pkg::*;
;

  localparam int DONE_TIMEOUT = 40;
  localparam int RANDOM_COUNT = 200;
  localparam int B2B_COUNT    = 20;
  localparam int HOLD_CYCLES  = 30;

  logic   clk;
  logic   rst;
  logic   start;
  bin_t   bin_in;
  digit_t units;
  digit_t tens;
  logic   done;

  logic [31:0] lfsr_state = 32'ha3ba_e713;
  int          checks       = 0;
  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          boundary_vals [8] = '{0, 4, 5, 9, 10, 49, 50, 99};

  bin_to_bcd i_bin_to_bcd (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .bin_in (bin_in),
    .units  (units),
    .tens   (tens),
    .done   (done)
  );

  bind bcd_shift_control bin_to_bcd_assert i_bin_to_bcd_assert (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .clear    (clear),
    .shift_en (shift_en),
    .adj_en   (adj_en),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;  // Taps for x^32 + x^22 + x^2 + x + 1.
    end
    return n;
  endfunction

  // Takes seven bits per draw and redraws anything above 99.
  task automatic draw_value(output bin_t value);
    bin_t raw;
    do begin
      raw = '0;
      for (int b = 0; b < BIN_W; b++) begin
        raw        = {raw[BIN_W-2:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
      end
    end while (raw > 99);
    value = raw;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Tens is the value divided by ten, units the remainder.
  task automatic check_result(input string name, input int value);
    check_value({name, " done"}, 0, done);
    check_value({name, " tens"}, value / 10, tens);
    check_value({name, " units"}, value % 10, units);
  endtask

  task automatic await_done(input string name, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (done === 1'b1) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      errors++;
      $display("%s: done never arrived within %0d cycles", name, DONE_TIMEOUT);
    end
  endtask

  // One start edge, then the digits are read one cycle after done.
  task automatic convert(input string name, input bin_t value);
    bit seen;
    @(posedge clk);
    start  <= 1'b1;
    bin_in <= value;
    @(posedge clk);
    start  <= 1'b0;
    await_done(name, seen);
    @(negedge clk);
    check_result(name, value);
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - err_mark);
    end
  endtask

  initial begin
    bin_t value;
    bin_t other;
    bin_t next;
    bit   seen;
    int   err_mark;

    rst    <= 1'b1;
    start  <= 1'b0;
    bin_in <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    err_mark = errors;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_result("reset_state", 0);
    end
    report_test("reset_state", err_mark);

    err_mark = errors;
    foreach (boundary_vals[i]) begin
      convert($sformatf("boundary_%0d", boundary_vals[i]), bin_t'(boundary_vals[i]));
    end
    report_test("boundary_values", err_mark);

    err_mark = errors;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      draw_value(value);
      convert($sformatf("random_%0d", i), value);
    end
    report_test("random_conversions", err_mark);

    err_mark = errors;
    draw_value(value);
    other = bin_t'((value + 37) % 100);
    @(posedge clk);
    start  <= 1'b1;
    bin_in <= value;
    @(posedge clk);
    bin_in <= other;  // The operand was already taken on this edge.
    await_done("start_while_busy", seen);
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_result("start_while_busy", value);
    convert("start_while_busy_next", other);
    report_test("start_while_busy", err_mark);

    err_mark = errors;
    draw_value(value);
    convert("result_hold", value);
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(negedge clk);
      check_result("result_hold", value);
    end
    report_test("result_hold", err_mark);

    err_mark = errors;
    draw_value(next);
    @(posedge clk);
    start  <= 1'b1;
    bin_in <= next;
    for (int i = 0; i < B2B_COUNT; i++) begin
      value = next;
      @(posedge clk);
      start <= 1'b0;
      await_done($sformatf("back_to_back_%0d", i), seen);
      if (i < B2B_COUNT - 1) begin
        draw_value(next);
      end
      @(posedge clk);
      if (i < B2B_COUNT - 1) begin
        start  <= 1'b1;  // Seen on the first idle cycle.
        bin_in <= next;
      end
      @(negedge clk);
      check_result($sformatf("back_to_back_%0d", i), value);
    end
    report_test("back_to_back", err_mark);

    if (i_bin_to_bcd.i_bcd_shift_control.i_bin_to_bcd_assert.fail_count != 0) begin
      errors += i_bin_to_bcd.i_bcd_shift_control.i_bin_to_bcd_assert.fail_count;
      $display("%0d control assertion(s) failed during the run",
               i_bin_to_bcd.i_bcd_shift_control.i_bin_to_bcd_assert.fail_count);
    end

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/bcd_pkg.sv
logic/bcd_shift_control.sv
logic/bcd_datapath.sv
logic/bin_to_bcd.sv
bench/bin_to_bcd_assert.sv
bench/bin_to_bcd_tb.sv

// File: Bender.yml
package:
  name: bin_to_bcd

sources:
  # RTL sources in compile order.
  - logic/bcd_pkg.sv
  - logic/bcd_shift_control.sv
  - logic/bcd_datapath.sv
  - logic/bin_to_bcd.sv

  # Testbench sources.
  - target: test
    files:
      - bench/bin_to_bcd_assert.sv
      - bench/bin_to_bcd_tb.sv
